/* src.f */
+incdir+rtl
rtl/id_pkg.sv
rtl/register_bank.sv
rtl/control_unit.sv
rtl/id_stage.sv
dv/tb_id_stage.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the ID stage testbench with Verilator, runs it and checks the log
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert \
    -f src.f \
    --top-module tb_id_stage \
    -o sim_tb_id_stage

./obj_dir/sim_tb_id_stage | tee "$LOG"

if grep -q "^Test completed successfully$" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation did not pass, see $LOG"
    exit 1
fi

/* dv/tb_id_stage.sv */
`include "id_settings.svh"

`default_nettype none

module tb_id_stage
    import id_pkg::*;
();

    localparam int CLK_PERIOD = 40;
    localparam int N_WRITES   = `ID_N_REGS;   // r0 included, must stay zero

    // Expected control flags, one bit per single-bit ctrl_t field
    localparam logic [13:0] F_RD  = 14'h2000;
    localparam logic [13:0] F_IMM = 14'h1000;
    localparam logic [13:0] F_VAR = 14'h0800;
    localparam logic [13:0] F_MR  = 14'h0400;
    localparam logic [13:0] F_MW  = 14'h0200;
    localparam logic [13:0] F_SGN = 14'h0100;
    localparam logic [13:0] F_BR  = 14'h0080;
    localparam logic [13:0] F_BNE = 14'h0040;
    localparam logic [13:0] F_WR  = 14'h0020;
    localparam logic [13:0] F_M2R = 14'h0010;
    localparam logic [13:0] F_J   = 14'h0008;
    localparam logic [13:0] F_JR  = 14'h0004;
    localparam logic [13:0] F_LNK = 14'h0002;
    localparam logic [13:0] F_HLT = 14'h0001;

    typedef struct packed {
        logic [31:0] inst;
        ctrl_t       ctrl;
    } vec_t;

    logic                   clk;
    logic                   rst;
    logic                   stall_enable;
    logic                   rb_enable;
    logic                   flush;
    logic                   dbg_read_enable;
    logic [`ID_NB_REG-1:0]  dbg_read_address;
    logic [31:0]            inst;
    logic [`ID_NB_PC-1:0]   next_pc;
    wb_t                    wb;
    id_ex_t                 id_ex;
    logic [`ID_NB_DATA-1:0] dbg_data;

    vec_t                   table_q[$];
    logic [`ID_NB_DATA-1:0] shadow [`ID_N_REGS];   // Reference register contents
    logic                   table_ready;
    int                     errors;
    int                     checks;

    id_stage u_dut (
        .i_clock            (clk),
        .i_rst              (rst),
        .i_stall_enable     (stall_enable),
        .i_rb_enable        (rb_enable),
        .i_flush            (flush),
        .i_dbg_read_enable  (dbg_read_enable),
        .i_dbg_read_address (dbg_read_address),
        .i_inst             (inst),
        .i_next_pc          (next_pc),
        .i_wb               (wb),
        .o_id_ex            (id_ex),
        .o_dbg_data         (dbg_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic ctrl_t make_ctrl(input alu_op_e op, input mem_size_e sz,
                                        input logic [13:0] f);
        ctrl_t c;
        c             = '0;
        c.alu_op      = op;
        c.mem_size    = sz;
        c.reg_dest    = f[13];
        c.alu_src     = f[12];
        c.shift_var   = f[11];
        c.mem_read    = f[10];
        c.mem_write   = f[9];
        c.load_signed = f[8];
        c.branch      = f[7];
        c.branch_ne   = f[6];
        c.reg_write   = f[5];
        c.mem_to_reg  = f[4];
        c.jump        = f[3];
        c.jr_jalr     = f[2];
        c.link        = f[1];
        c.hlt         = f[0];
        return c;
    endfunction

    function automatic id_ex_t expect_record(input logic [31:0] word,
                                             input logic [`ID_NB_PC-1:0] pc,
                                             input ctrl_t c, input logic flushed);
        id_ex_t     e;
        logic [5:0] op;
        op = word[31:26];
        e  = '0;
        if (!flushed) begin
            e.ctrl = c;
        end
        e.pc     = pc;
        e.rs     = word[25:21];
        e.rt     = word[20:16];
        e.rd     = (op == OP_JAL) ? 5'(`ID_LINK_REG) : word[15:11];   // JAL links into r31
        e.data_a = shadow[e.rs];
        e.data_b = shadow[e.rt];
        e.shamt  = {27'd0, word[10:6]};
        if (op == OP_ANDI || op == OP_ORI || op == OP_XORI) begin
            e.immediate = {16'd0, word[15:0]};            // Logical ops zero-extend
        end else begin
            e.immediate = {{16{word[15]}}, word[15:0]};
        end
        // Register target for JR and JALR, else PC region plus word index
        e.jump_addr = c.jr_jalr ? e.data_a : {pc[31:28], word[25:0], 2'b00};
        return e;
    endfunction

    task automatic check_ctrl(input ctrl_t got, input ctrl_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] t=%0t %s: ctrl got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_word(input logic [`ID_NB_DATA-1:0] got,
                              input logic [`ID_NB_DATA-1:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] t=%0t %s: got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_record(input id_ex_t got, input id_ex_t exp, input string what);
        check_ctrl(got.ctrl, exp.ctrl, what);
        check_word(got.pc, exp.pc, {what, " pc"});
        check_word(got.data_a, exp.data_a, {what, " data_a"});
        check_word(got.data_b, exp.data_b, {what, " data_b"});
        check_word(got.immediate, exp.immediate, {what, " immediate"});
        check_word(got.shamt, exp.shamt, {what, " shamt"});
        check_word(32'(got.rs), 32'(exp.rs), {what, " rs"});
        check_word(32'(got.rt), 32'(exp.rt), {what, " rt"});
        check_word(32'(got.rd), 32'(exp.rd), {what, " rd"});
        check_word(got.jump_addr, exp.jump_addr, {what, " jump_addr"});
    endtask

    task automatic add_entry(input logic [5:0] op, input logic [5:0] fn, input alu_op_e alu,
                             input mem_size_e sz, input logic [13:0] f);
        vec_t        v;
        logic [31:0] r;
        r      = $urandom();
        v.inst = (op == 6'd0) ? {op, r[25:6], fn} : {op, r[25:0]};   // Random register fields
        v.ctrl = make_ctrl(alu, sz, f);
        table_q.push_back(v);
    endtask

    task automatic build_table();
        add_entry(OP_RTYPE, FN_SLL,  ALU_SLL, MEM_NONE, F_RD | F_WR);
        add_entry(OP_RTYPE, FN_SRL,  ALU_SRL, MEM_NONE, F_RD | F_WR);
        add_entry(OP_RTYPE, FN_SRA,  ALU_SRA, MEM_NONE, F_RD | F_WR);
        add_entry(OP_RTYPE, FN_SLLV, ALU_SLL, MEM_NONE, F_RD | F_WR | F_VAR);
        add_entry(OP_RTYPE, FN_SRLV, ALU_SRL, MEM_NONE, F_RD | F_WR | F_VAR);
        add_entry(OP_RTYPE, FN_SRAV, ALU_SRA, MEM_NONE, F_RD | F_WR | F_VAR);
        add_entry(OP_RTYPE, FN_JR,   ALU_ADD, MEM_NONE, F_RD | F_JR);
        add_entry(OP_RTYPE, FN_JALR, ALU_ADD, MEM_NONE, F_RD | F_WR | F_JR | F_LNK);
        add_entry(OP_RTYPE, FN_ADDU, ALU_ADD, MEM_NONE, F_RD | F_WR);
        add_entry(OP_RTYPE, FN_SUBU, ALU_SUB, MEM_NONE, F_RD | F_WR);
        add_entry(OP_RTYPE, FN_AND,  ALU_AND, MEM_NONE, F_RD | F_WR);
        add_entry(OP_RTYPE, FN_OR,   ALU_OR,  MEM_NONE, F_RD | F_WR);
        add_entry(OP_RTYPE, FN_XOR,  ALU_XOR, MEM_NONE, F_RD | F_WR);
        add_entry(OP_RTYPE, FN_NOR,  ALU_NOR, MEM_NONE, F_RD | F_WR);
        add_entry(OP_RTYPE, FN_SLT,  ALU_SLT, MEM_NONE, F_RD | F_WR);
        add_entry(OP_RTYPE, 6'h0c,   ALU_ADD, MEM_NONE, 14'h0);         // Unknown funct
        add_entry(OP_J,     6'd0,    ALU_ADD, MEM_NONE, F_J);
        add_entry(OP_JAL,   6'd0,    ALU_ADD, MEM_NONE, F_J | F_LNK | F_RD | F_WR);
        add_entry(OP_BEQ,   6'd0,    ALU_SUB, MEM_NONE, F_BR);
        add_entry(OP_BNE,   6'd0,    ALU_SUB, MEM_NONE, F_BR | F_BNE);
        add_entry(OP_ADDI,  6'd0,    ALU_ADD, MEM_NONE, F_IMM | F_WR);
        add_entry(OP_ADDIU, 6'd0,    ALU_ADD, MEM_NONE, F_IMM | F_WR);
        add_entry(OP_SLTI,  6'd0,    ALU_SLT, MEM_NONE, F_IMM | F_WR);
        add_entry(OP_ANDI,  6'd0,    ALU_AND, MEM_NONE, F_IMM | F_WR);
        add_entry(OP_ORI,   6'd0,    ALU_OR,  MEM_NONE, F_IMM | F_WR);
        add_entry(OP_XORI,  6'd0,    ALU_XOR, MEM_NONE, F_IMM | F_WR);
        add_entry(OP_LUI,   6'd0,    ALU_LUI, MEM_NONE, F_IMM | F_WR);
        add_entry(OP_LB,    6'd0,    ALU_ADD, MEM_BYTE, F_IMM | F_WR | F_MR | F_M2R | F_SGN);
        add_entry(OP_LH,    6'd0,    ALU_ADD, MEM_HALF, F_IMM | F_WR | F_MR | F_M2R | F_SGN);
        add_entry(OP_LW,    6'd0,    ALU_ADD, MEM_WORD, F_IMM | F_WR | F_MR | F_M2R | F_SGN);
        add_entry(OP_LBU,   6'd0,    ALU_ADD, MEM_BYTE, F_IMM | F_WR | F_MR | F_M2R);
        add_entry(OP_LHU,   6'd0,    ALU_ADD, MEM_HALF, F_IMM | F_WR | F_MR | F_M2R);
        add_entry(OP_SB,    6'd0,    ALU_ADD, MEM_BYTE, F_IMM | F_MW);
        add_entry(OP_SH,    6'd0,    ALU_ADD, MEM_HALF, F_IMM | F_MW);
        add_entry(OP_SW,    6'd0,    ALU_ADD, MEM_WORD, F_IMM | F_MW);
        add_entry(OP_HALT,  6'd0,    ALU_ADD, MEM_NONE, F_HLT);
        add_entry(6'h10,    6'd0,    ALU_ADD, MEM_NONE, 14'h0);         // Unknown opcode
    endtask

    task automatic write_reg(input logic [`ID_NB_REG-1:0] addr,
                             input logic [`ID_NB_DATA-1:0] data);
        wb.reg_write = 1'b1;
        wb.addr      = addr;
        wb.data      = data;
        @(negedge clk);
        wb.reg_write = 1'b0;
        if (addr != '0) begin
            shadow[addr] = data;                    // r0 ignores writes
        end
    endtask

    // One instruction in, one registered record out a cycle later
    task automatic decode_step(input logic [31:0] word, input ctrl_t exp_ctrl,
                               input logic flushed, input string what);
        logic [`ID_NB_PC-1:0] pc;
        id_ex_t               exp;
        pc           = $urandom() & 32'hffff_fffc;
        exp          = expect_record(word, pc, exp_ctrl, flushed);
        inst         = word;
        next_pc      = pc;
        stall_enable = 1'b1;
        flush        = flushed;
        @(negedge clk);
        check_record(id_ex, exp, what);
    endtask

    initial begin
        int     limit;
        wait (table_ready);
        limit = (table_q.size() + N_WRITES + 20) * CLK_PERIOD * 4;
        #(limit);
        $display("Simulation timed out after %0d time units", limit);
        $display("Test failed");
        $finish;
    end

    initial begin
        int                     seed;
        int                     k;
        logic [`ID_NB_DATA-1:0] wdata;
        id_ex_t                 held;
        ctrl_t                  addu_ctrl;

        seed             = $urandom(32'hedea);
        errors           = 0;
        checks           = 0;
        table_ready      = 1'b0;
        rst              = 1'b1;
        stall_enable     = 1'b0;
        rb_enable        = 1'b0;
        flush            = 1'b0;
        dbg_read_enable  = 1'b0;
        dbg_read_address = '0;
        inst             = '0;
        next_pc          = '0;
        wb               = '0;
        for (k = 0; k < `ID_N_REGS; k++) begin
            shadow[k] = '0;
        end
        build_table();
        addu_ctrl   = make_ctrl(ALU_ADD, MEM_NONE, F_RD | F_WR);
        table_ready = 1'b1;

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_record(id_ex, '0, "reset");

        rb_enable = 1'b1;
        for (k = 0; k < N_WRITES; k++) begin
            write_reg(k[4:0], $urandom());
        end

        for (k = 0; k < table_q.size(); k++) begin
            decode_step(table_q[k].inst, table_q[k].ctrl, 1'b0, $sformatf("entry %0d", k));
        end

        // Write and read of the same register in one cycle, then of r0
        k            = 1 + int'($urandom() % 31);
        wdata        = $urandom();
        wb.reg_write = 1'b1;
        wb.addr      = k[4:0];
        wb.data      = wdata;
        shadow[k]    = wdata;
        decode_step({OP_RTYPE, k[4:0], 5'd0, 5'd3, 5'd0, FN_ADDU}, addu_ctrl, 1'b0, "bypass");
        wb.addr      = '0;
        wb.data      = $urandom();
        decode_step({OP_RTYPE, 5'd0, 5'd0, 5'd4, 5'd0, FN_ADDU}, addu_ctrl, 1'b0, "bypass r0");
        wb.reg_write = 1'b0;

        held         = id_ex;
        inst         = ~inst;
        next_pc      = $urandom();
        stall_enable = 1'b0;                        // Record must hold
        repeat (2) begin
            @(negedge clk);
            check_record(id_ex, held, "stall");
        end

        decode_step(table_q[0].inst, table_q[0].ctrl, 1'b1, "flush");
        decode_step(table_q[1].inst, table_q[1].ctrl, 1'b0, "after flush");

        stall_enable = 1'b0;
        for (k = 0; k < `ID_N_REGS; k++) begin
            dbg_read_enable  = 1'b1;
            dbg_read_address = k[4:0];
            @(negedge clk);
            check_word(dbg_data, shadow[k], $sformatf("debug r%0d", k));
        end
        dbg_read_enable  = 1'b0;
        dbg_read_address = 5'd1;
        @(negedge clk);
        check_word(dbg_data, shadow[`ID_N_REGS-1], "debug hold");

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/id_stage.sv */
`include "id_settings.svh"

`default_nettype none

module id_stage
    import id_pkg::*;
(
    input  wire logic                   i_clock,
    input  wire logic                   i_rst,
    input  wire logic                   i_stall_enable,      // From debug unit, low holds
    input  wire logic                   i_rb_enable,         // From debug unit
    input  wire logic                   i_flush,             // From hazard unit
    input  wire logic                   i_dbg_read_enable,
    input  wire logic [`ID_NB_REG-1:0]  i_dbg_read_address,
    input  wire logic [31:0]            i_inst,
    input  wire logic [`ID_NB_PC-1:0]   i_next_pc,
    input  wire wb_t                    i_wb,
    output id_ex_t                      o_id_ex,
    output logic [`ID_NB_DATA-1:0]      o_dbg_data
);

    logic [`ID_NB_REG-1:0]  rs;
    logic [`ID_NB_REG-1:0]  rt;
    logic [`ID_NB_REG-1:0]  rd;
    opcode_e                opcode;
    funct_e                 funct;
    ctrl_t                  ctrl;
    logic [`ID_NB_DATA-1:0] data_a;
    logic [`ID_NB_DATA-1:0] data_b;
    logic [`ID_NB_DATA-1:0] immediate;
    logic [`ID_NB_DATA-1:0] shamt;
    logic [`ID_NB_PC-1:0]   jump_addr;
    id_ex_t                 id_ex_d;

    // Instruction fields
    assign rs     = i_inst[25:21];
    assign rt     = i_inst[20:16];
    assign rd     = i_inst[15:11];
    assign opcode = opcode_e'(i_inst[31:26]);
    assign funct  = funct_e'(i_inst[5:0]);

    register_bank u_register_bank (
        .i_clock            (i_clock),
        .i_rst              (i_rst),
        .i_enable           (i_rb_enable),
        .i_wb               (i_wb),
        .i_read_reg_a       (rs),
        .i_read_reg_b       (rt),
        .i_dbg_read_enable  (i_dbg_read_enable),
        .i_dbg_read_address (i_dbg_read_address),
        .o_data_a           (data_a),
        .o_data_b           (data_b),
        .o_dbg_data         (o_dbg_data)
    );

    control_unit u_control_unit (
        .i_opcode (opcode),
        .i_funct  (funct),
        .o_ctrl   (ctrl)
    );

    always_comb begin
        case (opcode)
            OP_ANDI, OP_ORI, OP_XORI: immediate = {{(`ID_NB_DATA-16){1'b0}}, i_inst[15:0]};
            default:                  immediate = {{(`ID_NB_DATA-16){i_inst[15]}}, i_inst[15:0]};
        endcase
    end

    assign shamt = {{(`ID_NB_DATA-5){1'b0}}, i_inst[10:6]};

    // Region bits of PC+4, then word index
    assign jump_addr = ctrl.jr_jalr ? data_a
                                    : {i_next_pc[`ID_NB_PC-1 -: 4], i_inst[25:0], 2'b00};

    always_comb begin
        id_ex_d           = '0;
        id_ex_d.ctrl      = ctrl;
        id_ex_d.pc        = i_next_pc;
        id_ex_d.data_a    = data_a;
        id_ex_d.data_b    = data_b;
        id_ex_d.immediate = immediate;
        id_ex_d.shamt     = shamt;
        id_ex_d.rs        = rs;
        id_ex_d.rt        = rt;
        id_ex_d.jump_addr = jump_addr;
        // JAL has no rd field, its return address goes to the link register
        id_ex_d.rd        = (ctrl.link && ctrl.jump) ? `ID_NB_REG'(`ID_LINK_REG) : rd;
    end

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            o_id_ex <= '0;
        end else if (i_stall_enable) begin
            o_id_ex <= id_ex_d;
            if (i_flush) begin
                o_id_ex.ctrl <= '0;                 // Bubble, data still loads
            end
        end
    end

    a_reset_bubble : assert property (
        @(posedge i_clock) i_rst |=> (o_id_ex.ctrl == '0)
    );

endmodule

`default_nettype wire

/* rtl/control_unit.sv */
`default_nettype none

module control_unit
    import id_pkg::*;
(
    input  wire opcode_e i_opcode,
    input  wire funct_e  i_funct,
    output ctrl_t        o_ctrl
);

    always_comb begin
        o_ctrl = '0;                                // Unknown codes stay inactive
        case (i_opcode)
            OP_RTYPE: begin
                o_ctrl.reg_dest  = 1'b1;            // Destination rd
                o_ctrl.reg_write = 1'b1;
                case (i_funct)
                    FN_SLL:  o_ctrl.alu_op = ALU_SLL;
                    FN_SRL:  o_ctrl.alu_op = ALU_SRL;
                    FN_SRA:  o_ctrl.alu_op = ALU_SRA;
                    FN_SLLV: begin
                        o_ctrl.alu_op    = ALU_SLL;
                        o_ctrl.shift_var = 1'b1;
                    end
                    FN_SRLV: begin
                        o_ctrl.alu_op    = ALU_SRL;
                        o_ctrl.shift_var = 1'b1;
                    end
                    FN_SRAV: begin
                        o_ctrl.alu_op    = ALU_SRA;
                        o_ctrl.shift_var = 1'b1;
                    end
                    FN_JR: begin
                        o_ctrl.reg_write = 1'b0;    // Pure jump, nothing written
                        o_ctrl.jr_jalr   = 1'b1;
                    end
                    FN_JALR: begin
                        o_ctrl.jr_jalr = 1'b1;
                        o_ctrl.link    = 1'b1;      // Return address into rd
                    end
                    FN_ADDU: o_ctrl.alu_op = ALU_ADD;
                    FN_SUBU: o_ctrl.alu_op = ALU_SUB;
                    FN_AND:  o_ctrl.alu_op = ALU_AND;
                    FN_OR:   o_ctrl.alu_op = ALU_OR;
                    FN_XOR:  o_ctrl.alu_op = ALU_XOR;
                    FN_NOR:  o_ctrl.alu_op = ALU_NOR;
                    FN_SLT:  o_ctrl.alu_op = ALU_SLT;
                    default: o_ctrl = '0;
                endcase
            end
            OP_J: begin
                o_ctrl.jump = 1'b1;
            end
            OP_JAL: begin
                o_ctrl.jump      = 1'b1;
                o_ctrl.link      = 1'b1;
                o_ctrl.reg_dest  = 1'b1;            // rd forced to link reg at top level
                o_ctrl.reg_write = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                o_ctrl.branch    = 1'b1;
                o_ctrl.branch_ne = (i_opcode == OP_BNE);
                o_ctrl.alu_op    = ALU_SUB;         // Compare by subtraction
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                o_ctrl.alu_src   = 1'b1;
                o_ctrl.reg_write = 1'b1;            // Destination rt
                case (i_opcode)
                    OP_SLTI: o_ctrl.alu_op = ALU_SLT;
                    OP_ANDI: o_ctrl.alu_op = ALU_AND;
                    OP_ORI:  o_ctrl.alu_op = ALU_OR;
                    OP_XORI: o_ctrl.alu_op = ALU_XOR;
                    OP_LUI:  o_ctrl.alu_op = ALU_LUI;
                    default: o_ctrl.alu_op = ALU_ADD;
                endcase
            end
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: begin
                o_ctrl.alu_src     = 1'b1;          // Base plus offset
                o_ctrl.reg_write   = 1'b1;
                o_ctrl.mem_read    = 1'b1;
                o_ctrl.mem_to_reg  = 1'b1;
                o_ctrl.load_signed = (i_opcode == OP_LB) || (i_opcode == OP_LH)
                                     || (i_opcode == OP_LW);
                case (i_opcode)
                    OP_LB, OP_LBU: o_ctrl.mem_size = MEM_BYTE;
                    OP_LH, OP_LHU: o_ctrl.mem_size = MEM_HALF;
                    default:       o_ctrl.mem_size = MEM_WORD;
                endcase
            end
            OP_SB, OP_SH, OP_SW: begin
                o_ctrl.alu_src   = 1'b1;
                o_ctrl.mem_write = 1'b1;
                case (i_opcode)
                    OP_SB:   o_ctrl.mem_size = MEM_BYTE;
                    OP_SH:   o_ctrl.mem_size = MEM_HALF;
                    default: o_ctrl.mem_size = MEM_WORD;
                endcase
            end
            OP_HALT: begin
                o_ctrl.hlt = 1'b1;
            end
            default: o_ctrl = '0;
        endcase

        // A single access per instruction across the whole table
        a_rd_wr_exclusive : assert (!(o_ctrl.mem_read && o_ctrl.mem_write));
    end

endmodule

`default_nettype wire

/* rtl/register_bank.sv */
`include "id_settings.svh"

`default_nettype none

module register_bank
    import id_pkg::*;
(
    input  wire logic                   i_clock,
    input  wire logic                   i_rst,
    input  wire logic                   i_enable,            // From debug unit
    input  wire wb_t                    i_wb,
    input  wire logic [`ID_NB_REG-1:0]  i_read_reg_a,
    input  wire logic [`ID_NB_REG-1:0]  i_read_reg_b,
    input  wire logic                   i_dbg_read_enable,
    input  wire logic [`ID_NB_REG-1:0]  i_dbg_read_address,
    output logic [`ID_NB_DATA-1:0]      o_data_a,
    output logic [`ID_NB_DATA-1:0]      o_data_b,
    output logic [`ID_NB_DATA-1:0]      o_dbg_data
);

    logic [`ID_NB_DATA-1:0] regs [`ID_N_REGS];
    logic                   wr_en;

    // Zero register, then same-cycle bypass, then stored word
    function automatic logic [`ID_NB_DATA-1:0] bypass_read(
        input logic [`ID_NB_REG-1:0]  addr,
        input logic [`ID_NB_DATA-1:0] stored,
        input logic                   write,
        input wb_t                    wb
    );
        if (addr == '0) begin
            return '0;
        end
        if (write && (wb.addr == addr)) begin
            return wb.data;
        end
        return stored;
    endfunction

    assign wr_en = i_wb.reg_write && i_enable && (i_wb.addr != '0);   // r0 is hardwired

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            for (int i = 0; i < `ID_N_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[i_wb.addr] <= i_wb.data;
        end
    end

    assign o_data_a = bypass_read(i_read_reg_a, regs[i_read_reg_a], wr_en, i_wb);
    assign o_data_b = bypass_read(i_read_reg_b, regs[i_read_reg_b], wr_en, i_wb);

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            o_dbg_data <= '0;
        end else if (i_dbg_read_enable) begin
            o_dbg_data <= regs[i_dbg_read_address];   // Holds while enable is low
        end
    end

    a_r0_zero : assert property (@(posedge i_clock) disable iff (i_rst) regs[0] == '0);

    // Writeback stage must stay quiet while the bank is being cleared
    a_no_write_in_reset : assert property (
        @(posedge i_clock) i_rst |-> !(i_wb.reg_write && i_enable)
    );

endmodule

`default_nettype wire

/* rtl/id_pkg.sv */
`include "id_settings.svh"

`default_nettype none

package id_pkg;

    // Primary opcode, instruction bits 31:26
    typedef enum logic [5:0] {
        OP_RTYPE = 6'b000000,
        OP_J     = 6'b000010,
        OP_JAL   = 6'b000011,
        OP_BEQ   = 6'b000100,
        OP_BNE   = 6'b000101,
        OP_ADDI  = 6'b001000,
        OP_ADDIU = 6'b001001,
        OP_SLTI  = 6'b001010,
        OP_ANDI  = 6'b001100,
        OP_ORI   = 6'b001101,
        OP_XORI  = 6'b001110,
        OP_LUI   = 6'b001111,
        OP_LB    = 6'b100000,
        OP_LH    = 6'b100001,
        OP_LW    = 6'b100011,
        OP_LBU   = 6'b100100,
        OP_LHU   = 6'b100101,
        OP_SB    = 6'b101000,
        OP_SH    = 6'b101001,
        OP_SW    = 6'b101011,
        OP_HALT  = 6'b111111
    } opcode_e;

    // R-type function code, instruction bits 5:0
    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_SLLV = 6'b000100,
        FN_SRLV = 6'b000110,
        FN_SRAV = 6'b000111,
        FN_JR   = 6'b001000,
        FN_JALR = 6'b001001,
        FN_ADDU = 6'b100001,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_NOR  = 6'b100111,
        FN_SLT  = 6'b101010
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_NONE, MEM_BYTE, MEM_HALF, MEM_WORD
    } mem_size_e;

    // All-zero value is the inactive word (a bubble)
    typedef struct packed {
        logic      reg_dest;        // 1 selects rd, 0 selects rt
        logic      alu_src;         // 1 selects immediate as operand B
        alu_op_e   alu_op;
        logic      shift_var;       // Shift amount from rs instead of shamt
        logic      mem_read;
        logic      mem_write;
        mem_size_e mem_size;
        logic      load_signed;
        logic      branch;
        logic      branch_ne;       // BNE instead of BEQ
        logic      reg_write;
        logic      mem_to_reg;
        logic      jump;
        logic      jr_jalr;         // Target comes from rs
        logic      link;            // Write return address
        logic      hlt;
    } ctrl_t;

    typedef struct packed {
        logic                   reg_write;
        logic [`ID_NB_REG-1:0]  addr;
        logic [`ID_NB_DATA-1:0] data;
    } wb_t;

    typedef struct packed {
        ctrl_t                  ctrl;
        logic [`ID_NB_PC-1:0]   pc;
        logic [`ID_NB_DATA-1:0] data_a;
        logic [`ID_NB_DATA-1:0] data_b;
        logic [`ID_NB_DATA-1:0] immediate;
        logic [`ID_NB_DATA-1:0] shamt;
        logic [`ID_NB_REG-1:0]  rs;
        logic [`ID_NB_REG-1:0]  rt;
        logic [`ID_NB_REG-1:0]  rd;
        logic [`ID_NB_PC-1:0]   jump_addr;
    } id_ex_t;

endpackage

`default_nettype wire

/* rtl/id_settings.svh */
`ifndef ID_SETTINGS_SVH
`define ID_SETTINGS_SVH

`default_nettype none

// Widths fixed by the MIPS-style ISA
`define ID_NB_DATA  32          // Register data width
`define ID_NB_PC    32          // Program counter width
`define ID_NB_REG   5           // Register address width

// Register bank layout
`define ID_N_REGS   32          // Number of architectural registers
`define ID_LINK_REG 31          // Return address register for JAL

`default_nettype wire

`endif
